//--- hw/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// geometry of the direct-mapped instruction cache
// one 32-bit word per line, so the offset only selects a byte in the word

`define ICACHE_LINES        16   // number of lines
`define ICACHE_INDEX_BITS   4    // log2 of line count
`define ICACHE_OFFSET_BITS  2    // byte within the word
`define ICACHE_TAG_BITS     26   // what is left of the 32-bit address

`endif

//--- hw/icache_addr_pkg.sv
`include "icache_macros.svh"

package icache_addr_pkg;

    // one instruction or address word
    typedef logic [31:0] icache_word_t;

    // lookup view of an address, msb first
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_INDEX_BITS-1:0]  index;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } icache_fields_t;

    // memory side and request capture see the raw word,
    // the tag and data stores decode the same bits as fields
    typedef union packed {
        icache_word_t   raw;
        icache_fields_t fields;
    } icache_addr_t;

endpackage

//--- hw/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // miss handling states of the cache controller
    //   idle      waiting for a fetch request
    //   compare   stores are read with the captured address
    //   allocate  line refill from memory in flight
    typedef enum logic [1:0] {
        state_idle     = 2'd0,
        state_compare  = 2'd1,
        state_allocate = 2'd2
    } icache_state_t;

endpackage

//--- hw/icache_tag_store.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_tag_store
    import icache_addr_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  icache_addr_t lookup_addr,
    input  logic         fill_en,
    output logic         hit
);

    logic [`ICACHE_LINES-1:0]    valid;
    logic [`ICACHE_TAG_BITS-1:0] tags [`ICACHE_LINES];

    logic [`ICACHE_INDEX_BITS-1:0] index;
    logic [`ICACHE_TAG_BITS-1:0]   tag;

    assign index = lookup_addr.fields.index;
    assign tag   = lookup_addr.fields.tag;

    // valid bits are the only control state here
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid <= '0;
        end
        else if (fill_en)
        begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tags[index] <= tag;   // tag goes in alongside the data word
        end
    end

    // combinational compare on the captured address
    assign hit = valid[index] && (tags[index] == tag);

endmodule

//--- hw/icache_data_store.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_data_store
    import icache_addr_pkg::*;
(
    input  logic         clk,
    input  icache_addr_t lookup_addr,
    input  logic         fill_en,
    input  icache_word_t fill_data,
    output icache_word_t read_data
);

    icache_word_t words [`ICACHE_LINES];

    logic [`ICACHE_INDEX_BITS-1:0] index;

    assign index = lookup_addr.fields.index;

    // refill write, one word per line
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            words[index] <= fill_data;
        end
    end

    // read is combinational so a hit answers in the compare cycle
    assign read_data = words[index];   // stale lines masked by tag store valid

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_ctrl
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  icache_word_t cpu_req_addr,
    input  logic         cpu_req_valid,
    output logic         cpu_req_ready,
    output icache_word_t cpu_req_data,

    input  logic         hit,
    input  icache_word_t read_data,
    output icache_addr_t lookup_addr,
    output logic         fill_en,
    output icache_word_t fill_data,

    output icache_word_t mem_req_addr,
    output logic         mem_req_valid,
    input  logic         mem_req_ready,
    input  icache_word_t mem_req_data
);

    icache_state_t state;
    icache_state_t state_next;

    icache_addr_t req_addr;    // captured fetch address
    icache_word_t resp_data;   // last word handed to the fetch side

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= state_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            state_idle:
            begin
                if (cpu_req_valid)
                begin
                    state_next = state_compare;
                end
            end
            state_compare:
            begin
                state_next = hit ? state_idle : state_allocate;
            end
            state_allocate:
            begin
                if (mem_req_ready)
                begin
                    state_next = state_compare;   // re-read after the fill
                end
            end
            default:
            begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == state_idle && cpu_req_valid)
        begin
            req_addr.raw <= cpu_req_addr;
        end
        if (cpu_req_ready)
        begin
            resp_data <= read_data;   // hold until the next hit
        end
    end

    assign lookup_addr = req_addr;

    // the hit answers in the same cycle, the register only holds it afterwards
    assign cpu_req_ready = (state == state_compare) && hit;
    assign cpu_req_data  = cpu_req_ready ? read_data : resp_data;

    // refill read, always word aligned
    assign mem_req_valid = (state == state_allocate);
    assign mem_req_addr  = {req_addr.raw[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

    assign fill_en   = mem_req_valid && mem_req_ready;
    assign fill_data = mem_req_data;

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ns

module icache_top
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // fetch side
    input  icache_word_t cpu_req_addr,
    input  logic         cpu_req_valid,
    output logic         cpu_req_ready,
    output icache_word_t cpu_req_data,

    // memory side, read only
    output icache_word_t mem_req_addr,
    output logic         mem_req_valid,
    input  logic         mem_req_ready,
    input  icache_word_t mem_req_data
);

    icache_addr_t lookup_addr;
    logic         hit;
    icache_word_t read_data;
    logic         fill_en;
    icache_word_t fill_data;

    icache_state_t ctrl_state;   // trace only, shows up by name in waves

    assign ctrl_state = icache_ctrl_inst.state;

    icache_tag_store icache_tag_store_inst (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .hit         (hit)
    );

    icache_data_store icache_data_store_inst (
        .clk         (clk),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_data   (fill_data),
        .read_data   (read_data)
    );

    icache_ctrl icache_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .hit           (hit),
        .read_data     (read_data),
        .lookup_addr   (lookup_addr),
        .fill_en       (fill_en),
        .fill_data     (fill_data),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

endmodule

//--- tests/icache_mem_model.sv
`timescale 1ns/1ns

module icache_mem_model
    import icache_addr_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  icache_word_t mem_req_addr,
    input  logic         mem_req_valid,
    output logic         mem_req_ready,
    output icache_word_t mem_req_data,
    output int unsigned  req_count,
    output icache_word_t last_addr
);

    localparam int unsigned SEED = 32'hb9d4_3c18;

    int unsigned delay;   // cycles left before the answer
    logic        busy;

    initial
    begin
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        req_count     = 0;
        last_addr     = '0;
        busy          = 1'b0;
        delay         = 0;
        void'($urandom(SEED));   // one seed for the whole run
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            req_count     <= 0;
            busy = 1'b0;
        end
        else
        begin
            mem_req_ready <= 1'b0;
            if (mem_req_valid && !mem_req_ready)
            begin
                if (!busy)
                begin
                    busy  = 1'b1;
                    delay = 1 + ($urandom % 4);   // latency of 1 to 4 cycles
                end
                delay = delay - 1;
                if (delay == 0)
                begin
                    mem_req_ready <= 1'b1;
                    mem_req_data  <= mem_req_addr ^ 32'h5a5a_0000;
                    last_addr     <= mem_req_addr;
                    req_count     <= req_count + 1;
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

//--- tests/icache_tb.sv
`timescale 1ns/1ns

module icache_tb
    import icache_addr_pkg::*;
;

    localparam int NUM_ENTRIES = 41;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 10 + 20;
    localparam int HIT_WAIT    = 2;   // negedges from drive to the hit answer

    typedef struct packed {
        icache_word_t addr;
        logic         miss;
        icache_word_t word;
    } stim_entry_t;

    logic         clk;
    logic         rst;
    icache_word_t cpu_req_addr;
    logic         cpu_req_valid;
    logic         cpu_req_ready;
    icache_word_t cpu_req_data;
    icache_word_t mem_req_addr;
    logic         mem_req_valid;
    logic         mem_req_ready;
    icache_word_t mem_req_data;
    int unsigned  mem_count;
    icache_word_t mem_last_addr;

    stim_entry_t stim_table [NUM_ENTRIES];
    int          cycle_count;

    icache_top icache_top_inst (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

    icache_mem_model icache_mem_model_inst (
        .clk           (clk),
        .rst           (rst),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .req_count     (mem_count),
        .last_addr     (mem_last_addr)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timed out after %0d cycles waiting for the cache", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_word(input string name, input icache_word_t got,
                              input icache_word_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_miss(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "miss flag mismatch");
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "latency mismatch");
        end
    endtask

    // address, miss expected, word expected (aligned address xor 5a5a0000)
    task automatic load_table();
        stim_table[0]  = {32'h0000_1000, 1'b1, 32'h5a5a_1000};   // cold miss
        stim_table[1]  = {32'h0000_1000, 1'b0, 32'h5a5a_1000};   // repeat hits
        stim_table[2]  = {32'h0000_1007, 1'b1, 32'h5a5a_1004};
        stim_table[3]  = {32'h0000_1005, 1'b0, 32'h5a5a_1004};   // same word, other byte
        stim_table[4]  = {32'h0000_1004, 1'b0, 32'h5a5a_1004};
        stim_table[5]  = {32'h0000_2000, 1'b1, 32'h5a5a_2000};   // index 0, new tag
        stim_table[6]  = {32'h0000_1000, 1'b1, 32'h5a5a_1000};
        stim_table[7]  = {32'h0000_2000, 1'b1, 32'h5a5a_2000};
        stim_table[8]  = {32'h0000_2000, 1'b0, 32'h5a5a_2000};
        // first sweep over all 16 indices
        stim_table[9]  = {32'h0000_3000, 1'b1, 32'h5a5a_3000};
        stim_table[10] = {32'h0000_3004, 1'b1, 32'h5a5a_3004};
        stim_table[11] = {32'h0000_3008, 1'b1, 32'h5a5a_3008};
        stim_table[12] = {32'h0000_300c, 1'b1, 32'h5a5a_300c};
        stim_table[13] = {32'h0000_3010, 1'b1, 32'h5a5a_3010};
        stim_table[14] = {32'h0000_3014, 1'b1, 32'h5a5a_3014};
        stim_table[15] = {32'h0000_3018, 1'b1, 32'h5a5a_3018};
        stim_table[16] = {32'h0000_301c, 1'b1, 32'h5a5a_301c};
        stim_table[17] = {32'h0000_3020, 1'b1, 32'h5a5a_3020};
        stim_table[18] = {32'h0000_3024, 1'b1, 32'h5a5a_3024};
        stim_table[19] = {32'h0000_3028, 1'b1, 32'h5a5a_3028};
        stim_table[20] = {32'h0000_302c, 1'b1, 32'h5a5a_302c};
        stim_table[21] = {32'h0000_3030, 1'b1, 32'h5a5a_3030};
        stim_table[22] = {32'h0000_3034, 1'b1, 32'h5a5a_3034};
        stim_table[23] = {32'h0000_3038, 1'b1, 32'h5a5a_3038};
        stim_table[24] = {32'h0000_303c, 1'b1, 32'h5a5a_303c};
        // second sweep, byte offsets vary, every line must still be there
        stim_table[25] = {32'h0000_3000, 1'b0, 32'h5a5a_3000};
        stim_table[26] = {32'h0000_3005, 1'b0, 32'h5a5a_3004};
        stim_table[27] = {32'h0000_300a, 1'b0, 32'h5a5a_3008};
        stim_table[28] = {32'h0000_300f, 1'b0, 32'h5a5a_300c};
        stim_table[29] = {32'h0000_3010, 1'b0, 32'h5a5a_3010};
        stim_table[30] = {32'h0000_3015, 1'b0, 32'h5a5a_3014};
        stim_table[31] = {32'h0000_301a, 1'b0, 32'h5a5a_3018};
        stim_table[32] = {32'h0000_301f, 1'b0, 32'h5a5a_301c};
        stim_table[33] = {32'h0000_3020, 1'b0, 32'h5a5a_3020};
        stim_table[34] = {32'h0000_3025, 1'b0, 32'h5a5a_3024};
        stim_table[35] = {32'h0000_302a, 1'b0, 32'h5a5a_3028};
        stim_table[36] = {32'h0000_302f, 1'b0, 32'h5a5a_302c};
        stim_table[37] = {32'h0000_3030, 1'b0, 32'h5a5a_3030};
        stim_table[38] = {32'h0000_3035, 1'b0, 32'h5a5a_3034};
        stim_table[39] = {32'h0000_303a, 1'b0, 32'h5a5a_3038};
        stim_table[40] = {32'h0000_303f, 1'b0, 32'h5a5a_303c};
    endtask

    initial
    begin
        int unsigned count_before;
        int          waited;
        stim_entry_t entry;

        clk           = 1'b0;
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        cycle_count   = 0;
        load_table();

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            entry = stim_table[i];
            @(negedge clk);
            count_before = mem_count;
            if (i > 0)
            begin
                // previous answer must stay on the bus between responses
                check_word("cpu_req_data", cpu_req_data, stim_table[i-1].word);
            end
            @(posedge clk);
            cpu_req_addr  <= entry.addr;
            cpu_req_valid <= 1'b1;
            waited = 0;
            do
            begin
                @(negedge clk);
                waited++;
            end
            while (!cpu_req_ready);

            check_word("cpu_req_data", cpu_req_data, entry.word);
            check_miss("mem request seen", mem_count != count_before, entry.miss);
            if (entry.miss)
            begin
                check_word("mem_req_addr", mem_last_addr, entry.addr & 32'hffff_fffc);
            end
            else
            begin
                check_cycles("hit latency", waited, HIT_WAIT);   // one cycle after capture
            end

            @(posedge clk);
            cpu_req_valid <= 1'b0;
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/icache_addr_pkg.sv
hw/icache_ctrl_pkg.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/icache_addr_pkg.sv
      - hw/icache_ctrl_pkg.sv
      - hw/icache_tag_store.sv
      - hw/icache_data_store.sv
      - hw/icache_ctrl.sv
      - hw/icache_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/icache_mem_model.sv
      - tests/icache_tb.sv
